/* all.f */
hw/soc_pkg.sv
hw/wb_mux.sv
hw/block_ram.sv
hw/seg7.sv
hw/gpio.sv
hw/soc_top.sv
dv/soc_checker.sv
dv/soc_tb.sv

/* dv/soc_checker.sv */
module soc_checker (
    input logic clk_i,
    input logic reset_i,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i,
    input logic ram_stb_i,
    input logic seg_stb_i,
    input logic gpio_stb_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // the decoder must never select two slaves at once.
    one_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0({ram_stb_i, seg_stb_i, gpio_stb_i}))
        else $error("more than one slave strobe is high");

    ack_needs_request: assert property (@(posedge clk_i) disable iff (reset_i)
        ack_i |-> (cyc_i && stb_i))
        else $error("ack_o is high without cyc_i and stb_i");

    // nothing may be acknowledged straight out of reset.
    quiet_after_reset: assert property (@(posedge clk_i) reset_i |=> !ack_i)
        else $error("ack_o is high in the cycle after reset");

endmodule

bind wb_mux soc_checker bus_checker_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .cyc_i      (cyc_i),
    .stb_i      (stb_i),
    .ack_i      (ack_o),
    .ram_stb_i  (ram_stb_o),
    .seg_stb_i  (seg_stb_o),
    .gpio_stb_i (gpio_stb_o)
);

/* dv/soc_tb.sv */
module soc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RAM_ABITS  = 8;
    localparam int SCAN_BITS  = 3;
    localparam int GPIO_COUNT = 24;
    localparam logic [31:0] RAM_BASE  = 32'h0000_1000;
    localparam logic [31:0] SEG_BASE  = 32'h0000_0100;
    localparam logic [31:0] GPIO_BASE = 32'h0000_0200;
    // no more than this many bus transfers are issued below and each takes under 10 cycles.
    localparam int N_XFER   = 700;
    localparam int WD_CYCLES = N_XFER * 10 + 4 * 4 * (2 ** SCAN_BITS) + 200;
    // segments gfedcba for the digits F down to 0.
    localparam logic [15:0][6:0] HEX_SEGS = {
        7'b1110001, 7'b1111001, 7'b1011110, 7'b0111001, 7'b1111100, 7'b1110111,
        7'b1101111, 7'b1111111, 7'b0000111, 7'b1111101, 7'b1101101, 7'b1100110,
        7'b1001111, 7'b1011011, 7'b0000110, 7'b0111111
    };

    logic        clk;
    logic        reset;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] wdat;
    logic [3:0]  sel;
    logic [31:0] rdat;
    logic        ack;
    logic [7:0]  seg;
    logic [3:0]  an;
    logic [23:0] pins;
    logic [23:0] gpio_out;
    logic [23:0] gpio_oe;
    logic [31:0] seed = 32'hc53e_1af7;
    logic [31:0] ram_m [2 ** RAM_ABITS];
    logic [31:0] act_q [$];
    logic [31:0] exp_q [$];
    string       what_q [$];
    int          checks = 0;
    int          errors = 0;

    soc_top #(.RAM_ABITS(RAM_ABITS), .SCAN_BITS(SCAN_BITS), .GPIO_COUNT(GPIO_COUNT)) dut_i (
        .clk_i(clk), .reset_i(reset), .cyc_i(cyc), .stb_i(stb), .we_i(we), .adr_i(adr),
        .dat_i(wdat), .sel_i(sel), .dat_o(rdat), .ack_o(ack), .seg_o(seg), .an_o(an),
        .gpio_i(pins), .gpio_o(gpio_out), .gpio_oe_o(gpio_oe)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        seed = xorshift(seed);
        return seed;
    endfunction

    function automatic logic [31:0] ram_merge(input logic [31:0] old, input logic [31:0] nw,
                                              input logic [3:0] be);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = nw[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [31:0] gpio_ref(input logic [1:0] r, input logic [23:0] o,
                                             input logic [23:0] oe, input logic [23:0] p);
        case (r)
            2'd0: return {8'h00, o};
            2'd1: return {8'h00, oe};
            2'd2: return {8'h00, p};
            default: return 32'h0;
        endcase
    endfunction

    // a RAM transfer takes two cycles from strobe to ack and any other transfer takes one.
    function automatic int exp_latency(input logic [31:0] a);
        return ((a >> RAM_ABITS) == (RAM_BASE >> RAM_ABITS)) ? 2 : 1;
    endfunction

    function automatic void queue_check(input logic [31:0] act, input logic [31:0] exp,
                                        input string what);
        act_q.push_back(act);
        exp_q.push_back(exp);
        what_q.push_back(what);
    endfunction

    task automatic bus_xfer(input logic w, input logic [31:0] a, input logic [31:0] d,
                            input logic [3:0] be, output logic [31:0] rd);
        int lat;
        @(posedge clk);
        cyc  <= 1'b1;
        stb  <= 1'b1;
        we   <= w;
        adr  <= a;
        wdat <= d;
        sel  <= be;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!ack && lat < 8);
        if (!ack) begin
            $display("no acknowledge from address %h within %0d cycles", a, lat);
        end
        queue_check(32'(lat), 32'(exp_latency(a)), "ack latency");
        rd = rdat;
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic write_word(input logic [31:0] a, input logic [31:0] d, input logic [3:0] be);
        logic [31:0] rd;
        bus_xfer(1'b1, a, d, be, rd);
    endtask

    task automatic read_check(input logic [31:0] a, input logic [31:0] exp, input string what);
        logic [31:0] rd;
        bus_xfer(1'b0, a, 32'h0, 4'hf, rd);
        queue_check(rd, exp, what);
    endtask

    // watch two full scans and check the lit pattern against the selected digit.
    task automatic scan_check(input logic raw, input logic [31:0] word);
        int k;
        int prev;
        logic [7:0] lit;
        prev = -1;
        repeat (2 * 4 * (2 ** SCAN_BITS)) begin
            @(posedge clk);
            k = 0;
            for (int i = 0; i < 4; i++) begin
                if (!an[i]) begin
                    k = i;
                end
            end
            lit = raw ? word[k*8 +: 8] : {1'b0, HEX_SEGS[word[k*4 +: 4]]};
            queue_check(32'($countones(~an)), 32'd1, "active digits");
            queue_check({24'h0, seg}, {24'h0, ~lit}, "seg_o");
            if (prev >= 0 && k != prev) begin
                queue_check(32'(k), 32'((prev + 1) % 4), "scan order");
            end
            prev = k;
        end
    endtask

    always @(posedge clk) begin
        while (exp_q.size() > 0) begin
            checks++;
            if (act_q[0] !== exp_q[0]) begin
                errors++;
                $display("** Error at %0t ns: %s is %h, expected %h",
                         $time, what_q[0], act_q[0], exp_q[0]);
            end
            void'(act_q.pop_front());
            void'(exp_q.pop_front());
            void'(what_q.pop_front());
        end
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d clock cycles", WD_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] d;
        logic [23:0] out_m;
        logic [23:0] oe_m;
        logic [31:0] word;
        reset <= 1'b1;
        cyc   <= 1'b0;
        stb   <= 1'b0;
        we    <= 1'b0;
        adr   <= 32'h0;
        wdat  <= 32'h0;
        sel   <= 4'h0;
        pins  <= 24'h0;
        repeat (5) @(posedge clk);
        queue_check({28'h0, an}, 32'hf, "an_o in reset");
        queue_check({24'h0, seg}, 32'hff, "seg_o in reset");
        reset <= 1'b0;
        @(posedge clk);
        queue_check({31'h0, ack}, 32'h0, "ack_o after reset");
        queue_check({8'h0, gpio_out}, 32'h0, "gpio_o after reset");
        queue_check({8'h0, gpio_oe}, 32'h0, "gpio_oe_o after reset");

        // every RAM word gets a known value before the random traffic starts.
        for (int i = 0; i < 2 ** RAM_ABITS; i++) begin
            ram_m[i] = 32'h9e37_79b9 * (i + 1);
            write_word(RAM_BASE + i, ram_m[i], 4'hf);
        end
        repeat (200) begin
            r = next_rand();
            a = RAM_BASE + {24'h0, r[7:0]};
            d = next_rand();
            write_word(a, d, r[11:8]);
            ram_m[a[7:0]] = ram_merge(ram_m[a[7:0]], d, r[11:8]);
            r = next_rand();
            read_check(RAM_BASE + {24'h0, r[7:0]}, ram_m[r[7:0]], "RAM read");
        end

        r = next_rand();
        out_m = r[23:0];
        r = next_rand();
        oe_m = r[23:0];
        write_word(GPIO_BASE, {8'h0, out_m}, 4'hf);
        write_word(GPIO_BASE + 1, {8'h0, oe_m}, 4'hf);
        read_check(GPIO_BASE, gpio_ref(2'd0, out_m, oe_m, 24'h0), "GPIO output reg");
        read_check(GPIO_BASE + 1, gpio_ref(2'd1, out_m, oe_m, 24'h0), "GPIO direction reg");
        queue_check({8'h0, gpio_out}, {8'h0, out_m}, "gpio_o");
        queue_check({8'h0, gpio_oe}, {8'h0, oe_m}, "gpio_oe_o");
        r = next_rand();
        pins <= r[23:0];
        // the read below is strobed two edges after the pins change.
        @(posedge clk);
        read_check(GPIO_BASE + 2, gpio_ref(2'd2, out_m, oe_m, r[23:0]), "GPIO input reg");
        write_word(GPIO_BASE + 2, 32'h0, 4'hf);
        read_check(GPIO_BASE + 2, gpio_ref(2'd2, out_m, oe_m, r[23:0]), "GPIO input reg");
        read_check(GPIO_BASE + 3, gpio_ref(2'd3, out_m, oe_m, r[23:0]), "GPIO reg 3");

        word = next_rand();
        write_word(SEG_BASE, word, 4'hf);
        write_word(SEG_BASE + 1, 32'h0, 4'hf);
        read_check(SEG_BASE, word, "display word");
        read_check(SEG_BASE + 1, 32'h0, "display mode");
        scan_check(1'b0, word);
        write_word(SEG_BASE + 1, 32'h1, 4'hf);
        read_check(SEG_BASE + 1, 32'h1, "display mode");
        scan_check(1'b1, word);

        // these unmapped words sit right next to the RAM, GPIO and display windows.
        read_check(32'h0000_0000, 32'hffff_ffff, "unmapped read");
        read_check(32'h0000_0102, 32'hffff_ffff, "unmapped read");
        read_check(32'h0000_0204, 32'hffff_ffff, "unmapped read");
        read_check(32'h0000_1100, 32'hffff_ffff, "unmapped read");
        write_word(32'h0000_1100, ~ram_m[0], 4'hf);
        write_word(32'h0000_0204, {8'h0, ~out_m}, 4'hf);
        write_word(32'h0000_0102, ~word, 4'hf);
        read_check(RAM_BASE, ram_m[0], "RAM after unmapped write");
        read_check(GPIO_BASE, {8'h0, out_m}, "GPIO after unmapped write");
        read_check(SEG_BASE, word, "display after unmapped write");

        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* hw/block_ram.sv */
module block_ram
    import soc_pkg::*;
#(
    parameter int RAM_ABITS = 10
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 stb_i,
    input  logic                 we_i,
    input  logic [SEL_W-1:0]     sel_i,
    input  logic [RAM_ABITS-1:0] addr_i,
    input  logic [DATA_W-1:0]    wdata_i,
    output logic [DATA_W-1:0]    rdata_o,
    output logic                 ack_o
);

    logic [SEL_W-1:0][7:0] mem [2**RAM_ABITS];
    logic [DATA_W-1:0]     rdata_q;
    logic                  ack_q;

    // the access happens in the first strobe cycle only.
    // the ack cycle that follows leaves the memory alone.
    always_ff @(posedge clk_i) begin
        if (stb_i && !ack_q) begin
            if (we_i) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (sel_i[b]) begin
                        mem[addr_i][b] <= wdata_i[b*8 +: 8];
                    end
                end
            end
            rdata_q <= mem[addr_i];
        end
    end

    // ack follows the strobe by one cycle and then drops for one cycle.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= stb_i & ~ack_q;
        end
    end

    assign rdata_o = rdata_q;
    assign ack_o   = ack_q;

endmodule

/* hw/gpio.sv */
module gpio
    import soc_pkg::*;
#(
    parameter int GPIO_COUNT = 24
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  logic [1:0]            addr_i,
    input  logic [DATA_W-1:0]     wdata_i,
    output logic [DATA_W-1:0]     rdata_o,
    input  logic [GPIO_COUNT-1:0] gpio_i,
    output logic [GPIO_COUNT-1:0] gpio_o,
    output logic [GPIO_COUNT-1:0] gpio_oe_o
);

    logic [GPIO_COUNT-1:0] out_q;
    logic [GPIO_COUNT-1:0] oe_q;
    logic [GPIO_COUNT-1:0] meta_q;
    logic [GPIO_COUNT-1:0] sync_q;

    // pins come up as inputs driving zero.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out_q <= '0;
            oe_q  <= '0;
        end else if (stb_i && we_i) begin
            case (addr_i)
                2'd0: out_q <= wdata_i[GPIO_COUNT-1:0];
                2'd1: oe_q  <= wdata_i[GPIO_COUNT-1:0];
                default: ;
            endcase
        end
    end

    // two flops take the pins into the clock domain.
    always_ff @(posedge clk_i) begin
        meta_q <= gpio_i;
        sync_q <= meta_q;
    end

    always_comb begin
        case (addr_i)
            2'd0: rdata_o = DATA_W'(out_q);
            2'd1: rdata_o = DATA_W'(oe_q);
            2'd2: rdata_o = DATA_W'(sync_q);
            default: rdata_o = '0;
        endcase
    end

    assign gpio_o    = out_q;
    assign gpio_oe_o = oe_q;

endmodule

/* hw/seg7.sv */
module seg7
    import soc_pkg::*;
#(
    parameter int SCAN_BITS = 16
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  logic              addr_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic [DATA_W-1:0] rdata_o,
    output logic [7:0]        seg_o,
    output logic [3:0]        an_o
);

    seg_word_u            disp_q;
    logic                 raw_q;
    logic [SCAN_BITS-1:0] cnt_q;
    logic [1:0]           dig_q;
    logic [1:0]           dig_nxt;
    logic [7:0]           lit;
    logic [3:0]           an_q;
    logic [7:0]           seg_q;

    // segments a..g sit in bits 0..6 and a set bit lights the segment.
    function automatic logic [7:0] hex_to_seg(input logic [3:0] val);
        logic [7:0] pat;
        case (val)
            4'h0: pat = 8'h3f;
            4'h1: pat = 8'h06;
            4'h2: pat = 8'h5b;
            4'h3: pat = 8'h4f;
            4'h4: pat = 8'h66;
            4'h5: pat = 8'h6d;
            4'h6: pat = 8'h7d;
            4'h7: pat = 8'h07;
            4'h8: pat = 8'h7f;
            4'h9: pat = 8'h6f;
            4'ha: pat = 8'h77;
            4'hb: pat = 8'h7c;
            4'hc: pat = 8'h39;
            4'hd: pat = 8'h5e;
            4'he: pat = 8'h79;
            default: pat = 8'h71;
        endcase
        return pat;
    endfunction

    always_ff @(posedge clk_i) begin
        if (stb_i && we_i) begin
            if (addr_i) begin
                raw_q <= wdata_i[0];
            end else begin
                disp_q <= wdata_i;
            end
        end
    end

    assign rdata_o = addr_i ? DATA_W'(raw_q) : disp_q;

    assign dig_nxt = (&cnt_q) ? dig_q + 2'd1 : dig_q;
    assign lit     = raw_q ? disp_q.seg[dig_nxt] : hex_to_seg(disp_q.nib[dig_nxt]);

    // reset parks the scan just before digit 0, so the first dwell is full length.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cnt_q <= '1;
            dig_q <= 2'd3;
            an_q  <= 4'b1111;
            seg_q <= 8'hff;
        end else begin
            cnt_q <= cnt_q + 1'b1;
            dig_q <= dig_nxt;
            an_q  <= ~(4'b0001 << dig_nxt);
            seg_q <= ~lit;
        end
    end

    assign an_o  = an_q;
    assign seg_o = seg_q;

endmodule

/* hw/soc_pkg.sv */
package soc_pkg;

    // each address holds one word and each byte of it has its own select.
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int SEL_W  = DATA_W / 8;

    // address map as match and mask pairs.
    // an address hits a slave when (adr & mask) == match.
    localparam logic [ADDR_W-1:0] GPIO_MATCH = 32'h0000_0200;
    localparam logic [ADDR_W-1:0] GPIO_MASK  = 32'hffff_fffc;
    localparam logic [ADDR_W-1:0] SEG_MATCH  = 32'h0000_0100;
    localparam logic [ADDR_W-1:0] SEG_MASK   = 32'hffff_fffe;

    // the RAM window starts at this base and spans 2**RAM_ABITS words.
    localparam logic [ADDR_W-1:0] RAM_MATCH  = 32'h0000_1000;

    // what the default slave returns for unmapped reads.
    localparam logic [DATA_W-1:0] DEFAULT_RDATA = '1;

    // the display word is decoded in one of two ways.
    // in the hex view nibble k holds the value of digit k and only nibbles 0..3 are shown.
    // in the raw view byte k holds the segment pattern of digit k with a set bit lit.
    typedef union packed {
        logic [7:0][3:0] nib;
        logic [3:0][7:0] seg;
    } seg_word_u;

endpackage

/* hw/soc_top.sv */
module soc_top
    import soc_pkg::*;
#(
    parameter int RAM_ABITS  = 10,
    parameter int SCAN_BITS  = 16,
    parameter int GPIO_COUNT = 24
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  cyc_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  logic [ADDR_W-1:0]     adr_i,
    input  logic [DATA_W-1:0]     dat_i,
    input  logic [SEL_W-1:0]      sel_i,
    output logic [DATA_W-1:0]     dat_o,
    output logic                  ack_o,
    output logic [7:0]            seg_o,
    output logic [3:0]            an_o,
    input  logic [GPIO_COUNT-1:0] gpio_i,
    output logic [GPIO_COUNT-1:0] gpio_o,
    output logic [GPIO_COUNT-1:0] gpio_oe_o
);

    logic                 ram_stb;
    logic                 seg_stb;
    logic                 gpio_stb;
    logic [RAM_ABITS-1:0] off;
    logic [DATA_W-1:0]    ram_rdata;
    logic                 ram_ack;
    logic [DATA_W-1:0]    seg_rdata;
    logic [DATA_W-1:0]    gpio_rdata;

    wb_mux #(.RAM_ABITS(RAM_ABITS)) mux_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .cyc_i        (cyc_i),
        .stb_i        (stb_i),
        .adr_i        (adr_i),
        .dat_o        (dat_o),
        .ack_o        (ack_o),
        .ram_stb_o    (ram_stb),
        .seg_stb_o    (seg_stb),
        .gpio_stb_o   (gpio_stb),
        .off_o        (off),
        .ram_rdata_i  (ram_rdata),
        .ram_ack_i    (ram_ack),
        .seg_rdata_i  (seg_rdata),
        .gpio_rdata_i (gpio_rdata)
    );

    // write data, write enable and selects fan out to every slave.
    block_ram #(.RAM_ABITS(RAM_ABITS)) ram_i (
        .clk_i   (clk_i),   .reset_i (reset_i), .stb_i   (ram_stb),
        .we_i    (we_i),    .sel_i   (sel_i),   .addr_i  (off),
        .wdata_i (dat_i),   .rdata_o (ram_rdata), .ack_o (ram_ack)
    );

    seg7 #(.SCAN_BITS(SCAN_BITS)) seg7_i (
        .clk_i   (clk_i),   .reset_i (reset_i), .stb_i   (seg_stb),
        .we_i    (we_i),    .addr_i  (off[0]),  .wdata_i (dat_i),
        .rdata_o (seg_rdata), .seg_o (seg_o),   .an_o    (an_o)
    );

    gpio #(.GPIO_COUNT(GPIO_COUNT)) io_i (
        .clk_i   (clk_i),   .reset_i (reset_i), .stb_i     (gpio_stb),
        .we_i    (we_i),    .addr_i  (off[1:0]), .wdata_i  (dat_i),
        .rdata_o (gpio_rdata), .gpio_i (gpio_i), .gpio_o   (gpio_o),
        .gpio_oe_o (gpio_oe_o)
    );

endmodule

/* hw/wb_mux.sv */
module wb_mux
    import soc_pkg::*;
#(
    parameter int RAM_ABITS = 10
) (
    input  logic                 clk_i,
    input  logic                 reset_i,

    // master side
    input  logic                 cyc_i,
    input  logic                 stb_i,
    input  logic [ADDR_W-1:0]    adr_i,
    output logic [DATA_W-1:0]    dat_o,
    output logic                 ack_o,

    // slave side
    output logic                 ram_stb_o,
    output logic                 seg_stb_o,
    output logic                 gpio_stb_o,
    output logic [RAM_ABITS-1:0] off_o,
    input  logic [DATA_W-1:0]    ram_rdata_i,
    input  logic                 ram_ack_i,
    input  logic [DATA_W-1:0]    seg_rdata_i,
    input  logic [DATA_W-1:0]    gpio_rdata_i
);

    // clear the low RAM_ABITS bits so the whole RAM window matches.
    localparam logic [ADDR_W-1:0] RAM_MASK =
        ~((ADDR_W'(1) << RAM_ABITS) - ADDR_W'(1));

    logic cs;
    logic gpio_hit;
    logic seg_hit;
    logic ram_hit;
    logic def_hit;
    logic ram_hit_q;

    assign cs = cyc_i & stb_i;

    // the first match in priority order wins.
    assign gpio_hit = (adr_i & GPIO_MASK) == GPIO_MATCH;
    assign seg_hit  = !gpio_hit && ((adr_i & SEG_MASK) == SEG_MATCH);
    assign ram_hit  = !gpio_hit && !seg_hit && ((adr_i & RAM_MASK) == RAM_MATCH);
    assign def_hit  = !gpio_hit && !seg_hit && !ram_hit;

    // only one slave ever sees a strobe.
    // the default region gets none, so writes there go nowhere.
    assign gpio_stb_o = cs & gpio_hit;
    assign seg_stb_o  = cs & seg_hit;
    assign ram_stb_o  = cs & ram_hit;

    assign off_o = adr_i[RAM_ABITS-1:0];

    // remembers that the RAM was strobed last cycle.
    // its registered ack is only passed on while that strobe is still held.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ram_hit_q <= 1'b0;
        end else begin
            ram_hit_q <= ram_stb_o;
        end
    end

    // seg7, gpio and the default slave answer in the strobe cycle.
    assign ack_o = (cs & (gpio_hit | seg_hit | def_hit))
                 | (ram_stb_o & ram_hit_q & ram_ack_i);

    always_comb begin
        if (gpio_hit) begin
            dat_o = gpio_rdata_i;
        end else if (seg_hit) begin
            dat_o = seg_rdata_i;
        end else if (ram_hit) begin
            dat_o = ram_rdata_i;
        end else begin
            dat_o = DEFAULT_RDATA;
        end
    end

endmodule

/* run.sh */
#!/bin/bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module soc_tb -f all.f -o soc_sim

./obj_dir/soc_sim 2>&1 | tee sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
